// ==== common/rcfg_pkg.sv ====
/*
 Shared constants and types for the PLL reconfiguration bridge.
 Holds the user and channel bus widths, the channel count, the soft CSR
 map and the channel address union. Modules refer to these by scoped
 names, for example rcfg_pkg::ADDR_BITS.
*/
`default_nettype none

package rcfg_pkg;

  // Channel count and the user address field that selects one
  localparam int NUM_CHANNELS = 2;
  localparam int CHAN_SEL_BITS = 1;

  // Bus widths
  localparam int ADDR_BITS = 10;
  localparam int USER_ADDR_BITS = ADDR_BITS + CHAN_SEL_BITS;
  localparam int USER_DATA_BITS = 32;
  localparam int CHAN_DATA_BITS = 8;

  // Bit 9 of a channel address picks the soft CSR over the transceiver port
  localparam int CSR_WINDOW_BIT = 9;
  localparam int CSR_OFFSET_BITS = 9;

  // Soft CSR map
  localparam logic [CSR_OFFSET_BITS-1:0] CSR_ID_OFFSET = 9'h000;
  localparam logic [CSR_OFFSET_BITS-1:0] CSR_STATUS_OFFSET = 9'h080;
  localparam logic [CSR_OFFSET_BITS-1:0] CSR_CONTROL_OFFSET = 9'h0E0;

  localparam logic [CHAN_DATA_BITS-1:0] PLL_CSR_ID = 8'hA5;

  // Depth of the status input synchronizers
  localparam int STATUS_SYNC_STAGES = 2;

  // One channel address, seen either as a raw transceiver register
  // address or as the CSR window flag with an offset below it
  typedef union packed {
    logic [ADDR_BITS-1:0] xcvr_view;
    struct packed {
      logic                       csr_window;
      logic [CSR_OFFSET_BITS-1:0] csr_offset;
    } csr_view;
  } chan_addr_u;

endpackage

`default_nettype wire

// ==== pll_csr/pll_soft_csr.sv ====
/*
 Soft CSR of one PLL channel.
 Offers an ID register, a status register fed by synchronized PLL status
 inputs, and a control register that can override the PLL powerdown.
 Accesses take a single cycle; read data is combinational from the offset.
*/
`timescale 1ns/1ns
`default_nettype none

module pll_soft_csr (
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  wire                                   csr_read,
  input  wire                                   csr_write,
  input  wire [rcfg_pkg::CSR_OFFSET_BITS-1:0]   csr_offset,
  input  wire [rcfg_pkg::CHAN_DATA_BITS-1:0]    csr_wdata,
  output logic [rcfg_pkg::CHAN_DATA_BITS-1:0]   csr_rdata,
  input  wire                                   pll_powerdown,
  input  wire                                   pll_locked,
  input  wire                                   pll_cal_busy,
  input  wire                                   pll_avmm_busy,
  output logic                                  out_pll_powerdown
);

  // Status synchronizer with locked in bit 0, cal_busy in bit 1 and avmm_busy in bit 2
  logic [rcfg_pkg::STATUS_SYNC_STAGES-1:0][2:0] status_sync;
  logic [2:0]                                   status_q;

  logic override_en;
  logic override_val;

  always_ff @(posedge clk) begin
    status_sync[0] <= {pll_avmm_busy, pll_cal_busy, pll_locked};
    for (int s = 1; s < rcfg_pkg::STATUS_SYNC_STAGES; s++) begin
      status_sync[s] <= status_sync[s-1];
    end
  end

  assign status_q = status_sync[rcfg_pkg::STATUS_SYNC_STAGES-1];

  // Control register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      override_en  <= 1'b0;
      override_val <= 1'b0;
    end else if (csr_write && (csr_offset == rcfg_pkg::CSR_CONTROL_OFFSET)) begin
      override_en  <= csr_wdata[0];
      override_val <= csr_wdata[1];
    end
  end

  // Powerdown follows the input unless overridden
  assign out_pll_powerdown = override_en ? override_val : pll_powerdown;

  always_comb begin
    csr_rdata = '0;
    if (csr_read) begin
      case (csr_offset)
        rcfg_pkg::CSR_ID_OFFSET: begin
          csr_rdata = rcfg_pkg::PLL_CSR_ID;
        end
        rcfg_pkg::CSR_STATUS_OFFSET: begin
          csr_rdata[2:0] = status_q;
          csr_rdata[3]   = out_pll_powerdown;
        end
        rcfg_pkg::CSR_CONTROL_OFFSET: begin
          csr_rdata[0] = override_en;
          csr_rdata[1] = override_val;
        end
        default: begin
          csr_rdata = '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/rcfg_request_decode.sv ====
/*
 Request decode for the shared reconfiguration slave.
 Captures one user access while idle, splits off the channel select from
 the top address bits and narrows the write data to one byte. The request
 is held toward the channels until the response stage reports rsp_done.
*/
`timescale 1ns/1ns
`default_nettype none

module rcfg_request_decode (
  input  wire                                       clk,
  input  wire                                       rst_n,
  input  wire                                       reconfig_read,
  input  wire                                       reconfig_write,
  input  wire [rcfg_pkg::USER_ADDR_BITS-1:0]        reconfig_address,
  input  wire [rcfg_pkg::USER_DATA_BITS-1:0]        reconfig_writedata,
  input  wire                                       rsp_done,
  output logic [rcfg_pkg::NUM_CHANNELS-1:0]         req_valid,
  output logic                                      req_is_read,
  output rcfg_pkg::chan_addr_u                      req_addr,
  output logic [rcfg_pkg::CHAN_DATA_BITS-1:0]       req_wdata
);

  logic [rcfg_pkg::CHAN_SEL_BITS-1:0] chan_sel;
  logic                               pending;
  logic                               capture;

  // A request is pending whenever some channel holds req_valid
  assign pending  = |req_valid;
  assign capture  = !pending && (reconfig_read || reconfig_write);
  assign chan_sel = reconfig_address[rcfg_pkg::USER_ADDR_BITS-1 -: rcfg_pkg::CHAN_SEL_BITS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_valid <= '0;
    end else if (capture) begin
      for (int i = 0; i < rcfg_pkg::NUM_CHANNELS; i++) begin
        req_valid[i] <= (chan_sel == rcfg_pkg::CHAN_SEL_BITS'(i));
      end
    end else if (rsp_done) begin
      req_valid <= '0;
    end
  end

  // Only the low byte of the write data goes to the channel
  always_ff @(posedge clk) begin
    if (capture) begin
      req_is_read         <= reconfig_read;
      req_addr.xcvr_view  <= reconfig_address[rcfg_pkg::ADDR_BITS-1:0];
      req_wdata           <= reconfig_writedata[rcfg_pkg::CHAN_DATA_BITS-1:0];
    end
  end

  a_no_read_and_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(reconfig_read && reconfig_write)
  );

endmodule

`default_nettype wire

// ==== design/chan_access_ctrl.sv ====
/*
 Per-channel access sequencer.
 Uses the CSR window flag of the held request to either run a single-cycle
 access on the soft CSR, or drive a strobe on the transceiver register port
 and hold it through back-pressure. Ends every access with a chan_done pulse
 and the read byte on chan_rdata.
*/
`timescale 1ns/1ns
`default_nettype none

module chan_access_ctrl (
  input  wire                                   clk,
  input  wire                                   rst_n,
  input  wire                                   req_valid,
  input  wire                                   req_is_read,
  input  rcfg_pkg::chan_addr_u                  req_addr,
  input  wire [rcfg_pkg::CHAN_DATA_BITS-1:0]    req_wdata,
  output logic                                  avmm_read,
  output logic                                  avmm_write,
  output logic [rcfg_pkg::ADDR_BITS-1:0]        avmm_address,
  output logic [rcfg_pkg::CHAN_DATA_BITS-1:0]   avmm_writedata,
  input  wire [rcfg_pkg::CHAN_DATA_BITS-1:0]    avmm_readdata,
  input  wire                                   avmm_waitrequest,
  input  wire                                   pll_powerdown,
  input  wire                                   pll_locked,
  input  wire                                   pll_cal_busy,
  input  wire                                   pll_avmm_busy,
  output logic                                  out_pll_powerdown,
  output logic                                  chan_done,
  output logic [rcfg_pkg::CHAN_DATA_BITS-1:0]   chan_rdata
);

  logic                                 is_csr;
  logic                                 served;
  logic                                 start;
  logic                                 xcvr_finish;
  logic                                 csr_read;
  logic                                 csr_write;
  logic [rcfg_pkg::CHAN_DATA_BITS-1:0]  csr_rdata;

  assign is_csr = req_addr.csr_view.csr_window;

  // served marks that the held request was already taken on
  assign start       = req_valid && !served;
  assign xcvr_finish = (avmm_read || avmm_write) && !avmm_waitrequest;

  assign csr_read  = start && is_csr && req_is_read;
  assign csr_write = start && is_csr && !req_is_read;

  // Address and data are held by decode for the whole access
  assign avmm_address   = req_addr.xcvr_view;
  assign avmm_writedata = req_wdata;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      served     <= 1'b0;
      avmm_read  <= 1'b0;
      avmm_write <= 1'b0;
      chan_done  <= 1'b0;
    end else begin
      chan_done <= 1'b0;
      if (!req_valid) begin
        served <= 1'b0;
      end else if (start) begin
        served <= 1'b1;
      end
      if (start && !is_csr) begin
        avmm_read  <= req_is_read;
        avmm_write <= !req_is_read;
      end else if (xcvr_finish) begin
        avmm_read  <= 1'b0;
        avmm_write <= 1'b0;
        chan_done  <= 1'b1;
      end
      // CSR accesses complete in the cycle they start
      if (start && is_csr) begin
        chan_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (csr_read) begin
      chan_rdata <= csr_rdata;
    end else if (avmm_read && !avmm_waitrequest) begin
      chan_rdata <= avmm_readdata;
    end
  end

  pll_soft_csr u_csr (
    .clk               (clk),
    .rst_n             (rst_n),
    .csr_read          (csr_read),
    .csr_write         (csr_write),
    .csr_offset        (req_addr.csr_view.csr_offset),
    .csr_wdata         (req_wdata),
    .csr_rdata         (csr_rdata),
    .pll_powerdown     (pll_powerdown),
    .pll_locked        (pll_locked),
    .pll_cal_busy      (pll_cal_busy),
    .pll_avmm_busy     (pll_avmm_busy),
    .out_pll_powerdown (out_pll_powerdown)
  );

  a_strobe_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(avmm_read && avmm_write)
  );

  // Strobe, address and data hold until the port accepts
  a_strobe_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    (avmm_read || avmm_write) && avmm_waitrequest |=>
      $stable({avmm_read, avmm_write, avmm_address, avmm_writedata})
  );

endmodule

`default_nettype wire

// ==== design/rcfg_response.sv ====
/*
 Response stage of the reconfiguration bridge.
 Takes the byte of whichever channel finished, zero-extends it onto the
 32-bit read data, and drops waitrequest for one cycle to end the access.
 The same cycle releases the pending request in decode.
*/
`timescale 1ns/1ns
`default_nettype none

module rcfg_response (
  input  wire                                                         clk,
  input  wire                                                         rst_n,
  input  wire [rcfg_pkg::NUM_CHANNELS-1:0]                            chan_done,
  input  wire [rcfg_pkg::NUM_CHANNELS*rcfg_pkg::CHAN_DATA_BITS-1:0]   chan_rdata,
  output logic [rcfg_pkg::USER_DATA_BITS-1:0]                         reconfig_readdata,
  output logic                                                        reconfig_waitrequest,
  output logic                                                        rsp_done
);

  logic [rcfg_pkg::CHAN_DATA_BITS-1:0] done_byte;

  // Only one channel finishes at a time, so an OR of masked bytes selects it
  always_comb begin
    done_byte = '0;
    for (int i = 0; i < rcfg_pkg::NUM_CHANNELS; i++) begin
      if (chan_done[i]) begin
        done_byte = done_byte | chan_rdata[i*rcfg_pkg::CHAN_DATA_BITS +: rcfg_pkg::CHAN_DATA_BITS];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_done <= 1'b0;
    end else begin
      rsp_done <= |chan_done;
    end
  end

  always_ff @(posedge clk) begin
    if (|chan_done) begin
      reconfig_readdata <= rcfg_pkg::USER_DATA_BITS'(done_byte);
    end
  end

  assign reconfig_waitrequest = !rsp_done;

  a_single_done: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(chan_done)
  );

endmodule

`default_nettype wire

// ==== design/rcfg_bridge_top.sv ====
/*
 Top level of the dual-channel PLL reconfiguration bridge.
 One shared user slave is decoded onto two channels, each with its own
 transceiver register port and soft CSR. Per-channel buses are packed
 into flat vectors, channel 0 in the low slice.
*/
`timescale 1ns/1ns
`default_nettype none

module rcfg_bridge_top (
  input  wire                                                         clk,
  input  wire                                                         rst_n,
  input  wire                                                         reconfig_read,
  input  wire                                                         reconfig_write,
  input  wire [rcfg_pkg::USER_ADDR_BITS-1:0]                          reconfig_address,
  input  wire [rcfg_pkg::USER_DATA_BITS-1:0]                          reconfig_writedata,
  output logic [rcfg_pkg::USER_DATA_BITS-1:0]                         reconfig_readdata,
  output logic                                                        reconfig_waitrequest,
  output logic [rcfg_pkg::NUM_CHANNELS-1:0]                           avmm_read,
  output logic [rcfg_pkg::NUM_CHANNELS-1:0]                           avmm_write,
  output logic [rcfg_pkg::NUM_CHANNELS*rcfg_pkg::ADDR_BITS-1:0]       avmm_address,
  output logic [rcfg_pkg::NUM_CHANNELS*rcfg_pkg::CHAN_DATA_BITS-1:0]  avmm_writedata,
  input  wire [rcfg_pkg::NUM_CHANNELS*rcfg_pkg::CHAN_DATA_BITS-1:0]   avmm_readdata,
  input  wire [rcfg_pkg::NUM_CHANNELS-1:0]                            avmm_waitrequest,
  input  wire [rcfg_pkg::NUM_CHANNELS-1:0]                            pll_powerdown,
  input  wire [rcfg_pkg::NUM_CHANNELS-1:0]                            pll_locked,
  input  wire [rcfg_pkg::NUM_CHANNELS-1:0]                            pll_cal_busy,
  input  wire [rcfg_pkg::NUM_CHANNELS-1:0]                            pll_avmm_busy,
  output logic [rcfg_pkg::NUM_CHANNELS-1:0]                           out_pll_powerdown
);

  localparam int DW = rcfg_pkg::CHAN_DATA_BITS;
  localparam int AW = rcfg_pkg::ADDR_BITS;

  logic [rcfg_pkg::NUM_CHANNELS-1:0]     req_valid;
  logic                                  req_is_read;
  rcfg_pkg::chan_addr_u                  req_addr;
  logic [DW-1:0]                         req_wdata;
  logic [rcfg_pkg::NUM_CHANNELS-1:0]     chan_done;
  logic [rcfg_pkg::NUM_CHANNELS*DW-1:0]  chan_rdata;
  logic                                  rsp_done;

  rcfg_request_decode u_decode (
    .clk                (clk),
    .rst_n              (rst_n),
    .reconfig_read      (reconfig_read),
    .reconfig_write     (reconfig_write),
    .reconfig_address   (reconfig_address),
    .reconfig_writedata (reconfig_writedata),
    .rsp_done           (rsp_done),
    .req_valid          (req_valid),
    .req_is_read        (req_is_read),
    .req_addr           (req_addr),
    .req_wdata          (req_wdata)
  );

  for (genvar ch = 0; ch < rcfg_pkg::NUM_CHANNELS; ch++) begin : g_chan
    chan_access_ctrl u_chan (
      .clk               (clk),
      .rst_n             (rst_n),
      .req_valid         (req_valid[ch]),
      .req_is_read       (req_is_read),
      .req_addr          (req_addr),
      .req_wdata         (req_wdata),
      .avmm_read         (avmm_read[ch]),
      .avmm_write        (avmm_write[ch]),
      .avmm_address      (avmm_address[ch*AW +: AW]),
      .avmm_writedata    (avmm_writedata[ch*DW +: DW]),
      .avmm_readdata     (avmm_readdata[ch*DW +: DW]),
      .avmm_waitrequest  (avmm_waitrequest[ch]),
      .pll_powerdown     (pll_powerdown[ch]),
      .pll_locked        (pll_locked[ch]),
      .pll_cal_busy      (pll_cal_busy[ch]),
      .pll_avmm_busy     (pll_avmm_busy[ch]),
      .out_pll_powerdown (out_pll_powerdown[ch]),
      .chan_done         (chan_done[ch]),
      .chan_rdata        (chan_rdata[ch*DW +: DW])
    );
  end

  rcfg_response u_response (
    .clk                  (clk),
    .rst_n                (rst_n),
    .chan_done            (chan_done),
    .chan_rdata           (chan_rdata),
    .reconfig_readdata    (reconfig_readdata),
    .reconfig_waitrequest (reconfig_waitrequest),
    .rsp_done             (rsp_done)
  );

endmodule

`default_nettype wire

// ==== verification/tb_rcfg_bridge.sv ====
/*
 Self-checking testbench for the dual-channel PLL reconfiguration bridge.
 Models each transceiver register port as a byte memory with random
 back-pressure, runs user accesses through the shared slave and lets
 concurrent assertions check strobes, read data, handshakes and powerdown.
 Ends with one summary line and the overall verdict.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_rcfg_bridge;

  logic clk;
  logic rst_n;
  logic reconfig_read;
  logic reconfig_write;
  logic [rcfg_pkg::USER_ADDR_BITS-1:0] reconfig_address;
  logic [rcfg_pkg::USER_DATA_BITS-1:0] reconfig_writedata;
  logic [rcfg_pkg::USER_DATA_BITS-1:0] reconfig_readdata;
  logic reconfig_waitrequest;
  logic [1:0] avmm_read;
  logic [1:0] avmm_write;
  logic [2*rcfg_pkg::ADDR_BITS-1:0] avmm_address;
  logic [2*rcfg_pkg::CHAN_DATA_BITS-1:0] avmm_writedata;
  logic [2*rcfg_pkg::CHAN_DATA_BITS-1:0] avmm_readdata;
  logic [1:0] avmm_waitrequest;
  logic [1:0] pll_powerdown;
  logic [1:0] pll_locked;
  logic [1:0] pll_cal_busy;
  logic [1:0] pll_avmm_busy;
  logic [1:0] out_pll_powerdown;

  // One byte memory per channel models each transceiver port
  logic [7:0] xmem [2][1024];
  logic [1:0] port_busy;
  logic [1:0] port_wr;
  int         stall_left [2];
  logic [9:0] port_addr [2];
  logic [7:0] port_wdata [2];

  // Expectations of the access in flight
  int          cur_chan;
  logic        exp_is_read;
  logic [9:0]  exp_addr;
  logic [7:0]  exp_byte;
  logic [31:0] exp_rdata;
  int          exp_strobes;
  int          strobe_cnt;
  logic        in_access;
  logic [1:0]  ovr_en;
  logic [1:0]  ovr_val;
  logic [1:0]  exp_pd;
  int          errors;
  int          n_access;

  rcfg_bridge_top DUT (.*);

  // Override value wins where enabled, the input elsewhere
  assign exp_pd = (ovr_en & ovr_val) | (~ovr_en & pll_powerdown);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(negedge clk) begin
    for (int ch = 0; ch < 2; ch++) begin
      // A low waitrequest from the last falling edge means the rising edge completed it
      if (port_busy[ch] && !avmm_waitrequest[ch]) begin
        if (port_wr[ch]) begin
          xmem[ch][port_addr[ch]] = port_wdata[ch];
        end
        port_busy[ch] = 1'b0;
        strobe_cnt++;
      end
      if ((avmm_read[ch] || avmm_write[ch]) && !port_busy[ch]) begin
        port_busy[ch]  = 1'b1;
        port_wr[ch]    = avmm_write[ch];
        port_addr[ch]  = avmm_address[ch*10 +: 10];
        port_wdata[ch] = avmm_writedata[ch*8 +: 8];
        stall_left[ch] = $urandom % 4;
      end
      avmm_waitrequest[ch] = !port_busy[ch] || (stall_left[ch] != 0);
      if (stall_left[ch] != 0) begin
        stall_left[ch]--;
      end
      avmm_readdata[ch*8 +: 8] = xmem[ch][avmm_address[ch*10 +: 10]];
    end
  end

  a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |->
    avmm_read == 2'b00 && avmm_write == 2'b00 && out_pll_powerdown == pll_powerdown)
    else begin
      errors++;
      $display("FAIL %0t avmm_read/avmm_write/out_pll_powerdown got %b/%b/%b expected 00/00/%b",
        $time, $sampled(avmm_read), $sampled(avmm_write), $sampled(out_pll_powerdown),
        $sampled(pll_powerdown));
    end

  for (genvar ch = 0; ch < 2; ch++) begin : g_port_chk
    a_strobe_chan: assert property (@(posedge clk) disable iff (!rst_n)
      (avmm_read[ch] || avmm_write[ch]) |-> cur_chan == ch)
      else begin
        errors++;
        $display("FAIL %0t avmm strobe channel got %0d expected %0d", $time, ch, cur_chan);
      end
    a_strobe_fields: assert property (@(posedge clk) disable iff (!rst_n)
      (avmm_read[ch] || avmm_write[ch]) && !avmm_waitrequest[ch] |->
        avmm_address[ch*10 +: 10] == exp_addr && avmm_read[ch] == exp_is_read &&
        (exp_is_read || avmm_writedata[ch*8 +: 8] == exp_byte))
      else begin
        errors++;
        $display("FAIL %0t avmm_read/avmm_address/avmm_writedata got %b/%h/%h expected %b/%h/%h",
          $time, $sampled(avmm_read[ch]), $sampled(avmm_address[ch*10 +: 10]),
          $sampled(avmm_writedata[ch*8 +: 8]), exp_is_read, exp_addr, exp_byte);
      end
  end

  a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
    !reconfig_waitrequest && reconfig_read |-> reconfig_readdata == exp_rdata)
    else begin
      errors++;
      $display("FAIL %0t reconfig_readdata got %h expected %h", $time,
        $sampled(reconfig_readdata), exp_rdata);
    end

  a_strobe_count: assert property (@(posedge clk) disable iff (!rst_n)
    !reconfig_waitrequest |-> strobe_cnt == exp_strobes)
    else begin
      errors++;
      $display("FAIL %0t completed avmm strobes got %0d expected %0d", $time,
        strobe_cnt, exp_strobes);
    end

  a_wait_low_once: assert property (@(posedge clk) disable iff (!rst_n)
    !reconfig_waitrequest |-> (reconfig_read || reconfig_write) ##1 reconfig_waitrequest)
    else begin
      errors++;
      $display("Waitrequest went low without a request or for more than one cycle at %0t",
        $time);
    end

  a_pd_follow: assert property (@(posedge clk) disable iff (!rst_n)
    !in_access |-> out_pll_powerdown == exp_pd)
    else begin
      errors++;
      $display("FAIL %0t out_pll_powerdown got %b expected %b", $time,
        $sampled(out_pll_powerdown), exp_pd);
    end

  // Runs one user access from a falling edge and returns on the falling edge after it
  task automatic run_access(input logic is_rd, input logic [10:0] addr,
                            input logic [31:0] wdata, input logic [31:0] expect_rd);
    int waited;
    int ch;
    waited      = 0;
    ch          = addr[10];
    cur_chan    = ch;
    exp_is_read = is_rd;
    exp_addr    = addr[9:0];
    exp_byte    = wdata[7:0];
    exp_rdata   = expect_rd;
    exp_strobes = addr[rcfg_pkg::CSR_WINDOW_BIT] ? 0 : 1;
    strobe_cnt  = 0;
    in_access   = 1'b1;
    reconfig_address   = addr;
    reconfig_writedata = wdata;
    reconfig_read      = is_rd;
    reconfig_write     = !is_rd;
    do begin
      @(negedge clk);
      waited++;
    end while (reconfig_waitrequest && waited < 40);
    if (reconfig_waitrequest) begin
      errors++;
      $display("Access to address %h got no response within %0d cycles", addr, waited);
    end else begin
      @(negedge clk);
    end
    reconfig_read  = 1'b0;
    reconfig_write = 1'b0;
    in_access      = 1'b0;
    n_access++;
    if (!is_rd && addr[9] && addr[8:0] == rcfg_pkg::CSR_CONTROL_OFFSET) begin
      ovr_en[ch]  = wdata[0];
      ovr_val[ch] = wdata[1];
    end
  endtask

  initial begin
    logic [10:0] addr;
    logic [31:0] wd;
    int ch;
    void'($urandom(32'h6a90_59b3));
    rst_n = 1'b0;
    reconfig_read = 1'b0;
    reconfig_write = 1'b0;
    reconfig_address = '0;
    reconfig_writedata = '0;
    avmm_readdata = '0;
    avmm_waitrequest = 2'b11;
    pll_powerdown = 2'b01;
    pll_locked = '0;
    pll_cal_busy = '0;
    pll_avmm_busy = '0;
    port_busy = '0;
    port_wr = '0;
    stall_left = '{0, 0};
    cur_chan = 0;
    exp_is_read = 1'b0;
    exp_addr = '0;
    exp_byte = '0;
    exp_rdata = '0;
    exp_strobes = 0;
    strobe_cnt = 0;
    in_access = 1'b0;
    ovr_en = '0;
    ovr_val = '0;
    errors = 0;
    n_access = 0;
    for (int a = 0; a < 1024; a++) begin
      xmem[0][a] = 8'(a) ^ 8'(a >> 5) ^ 8'h3C;
      xmem[1][a] = 8'(a) ^ 8'(a >> 5) ^ 8'hC3;
    end
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Transceiver write then read back on a random channel and register
    repeat (50) begin
      addr = {1'($urandom), 1'b0, 9'($urandom)};
      wd   = $urandom;
      run_access(1'b0, addr, wd, '0);
      run_access(1'b1, addr, '0, {24'h0, wd[7:0]});
    end

    for (int c = 0; c < 2; c++) begin
      run_access(1'b1, {1'(c), 1'b1, rcfg_pkg::CSR_ID_OFFSET}, '0, 32'h0000_00A5);
      run_access(1'b1, {1'(c), 1'b1, 9'h155}, '0, '0);
    end

    // Status bits after the synchronizer has settled
    repeat (8) begin
      ch = $urandom % 2;
      pll_locked    = 2'($urandom);
      pll_cal_busy  = 2'($urandom);
      pll_avmm_busy = 2'($urandom);
      pll_powerdown = 2'($urandom);
      repeat (4) @(negedge clk);
      run_access(1'b1, {1'(ch), 1'b1, rcfg_pkg::CSR_STATUS_OFFSET}, '0,
        {28'h0, exp_pd[ch], pll_avmm_busy[ch], pll_cal_busy[ch], pll_locked[ch]});
    end

    // Override each channel in turn while the inputs move underneath
    for (int c = 0; c < 2; c++) begin
      run_access(1'b0, {1'(c), 1'b1, rcfg_pkg::CSR_CONTROL_OFFSET}, 32'h3, '0);
      pll_powerdown = 2'b00;
      repeat (3) @(negedge clk);
      run_access(1'b0, {1'(c), 1'b1, rcfg_pkg::CSR_CONTROL_OFFSET}, 32'h1, '0);
      pll_powerdown = 2'b11;
      repeat (3) @(negedge clk);
      run_access(1'b0, {1'(c), 1'b1, rcfg_pkg::CSR_CONTROL_OFFSET}, 32'h0, '0);
      pll_powerdown = 2'b10;
      repeat (3) @(negedge clk);
    end

    repeat (4) @(negedge clk);
    $display("Summary: %0d accesses, %0d errors", n_access, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // Budget of 200 accesses at 12 cycles each plus reset
  initial begin
    #((16 + 200 * 12) * 100);
    $display("Watchdog expired before the test sequence finished");
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
common/rcfg_pkg.sv
pll_csr/pll_soft_csr.sv
design/rcfg_request_decode.sv
design/chan_access_ctrl.sv
design/rcfg_response.sv
design/rcfg_bridge_top.sv
verification/tb_rcfg_bridge.sv
